// ==== vlog.f ====
+incdir+.
decPkg.sv
pipeStage.sv
rvOpClassify.sv
rvRegFieldMap.sv
rvImmGen.sv
rvOperandRoute.sv
rvDecodeTop.sv
tbRvDecode.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - files:
      - decPkg.sv
      - pipeStage.sv
      - rvOpClassify.sv
      - rvRegFieldMap.sv
      - rvImmGen.sv
      - rvOperandRoute.sv
      - rvDecodeTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbRvDecode.sv

// ==== tbRvDecodeRef.svh ====
// ********************
// decoder reference model
// expected micro-op for one instruction word and mode
// ********************

function automatic uopT invUop();
	uopT u;
	u.nmid = ucInvop;
	u.uixt = '0;
	u.regN = grZzr;
	u.regM = grZzr;
	u.regO = grZzr;
	u.imm  = '0;
	return u;
endfunction

// fields 0..7 land on the special registers
function automatic gprT refReg(input logic [4:0] f);
	gprT specTbl [0:7];
	specTbl = '{grZzr, grLr, grSp, grGbr, grTbr, grDhr, grDlr, grR7};
	if (f < 5'd8)
		return specTbl[f[2:0]];
	return {2'b00, f};
endfunction

function automatic uopT refDecode(input logic [31:0] w, input logic [2:0] mode);
	uopT               u;
	logic [4:0]        opc;
	logic [2:0]        f3;
	gprT               rd;
	gprT               rs1;
	gprT               rs2;
	logic signed [11:0] i12;
	logic signed [11:0] s12;
	logic signed [11:0] b12;
	logic signed [19:0] j20;
	immT               immI;
	immT               immZ;
	immT               immS;
	immT               immB;
	immT               immJ;
	immT               immU;
	logic              word32;
	logic              regForm;
	logic [5:0]        cmpTbl [0:7];

	opc = w[6:2];
	f3  = w[14:12];
	rd  = refReg(w[11:7]);
	rs1 = refReg(w[19:15]);
	rs2 = refReg(w[24:20]);
	i12 = w[31:20];
	s12 = {w[31:25], w[11:7]};
	b12 = {w[31], w[7], w[30:25], w[11:8]}; // offset bits 12..1
	j20 = {w[31], w[19:12], w[20], w[30:21]}; // offset bits 20..1
	immI = i12; // signed source, sign extends
	immS = s12;
	immB = b12;
	immJ = j20;
	immZ = {21'd0, w[31:20]};
	immU = {1'b0, w[31:12], 12'd0};
	cmpTbl = '{ucixJcmpQeq, ucixJcmpQne, ucixJcmpQeq, ucixJcmpQeq,
		ucixJcmpQlt, ucixJcmpQge, ucixJcmpQbl, ucixJcmpQhs};
	u = invUop();

	if (w[1:0] != 2'b11)
		return u;
	if (w[11:7] == 5'd4 && mode[0])
		return u; // user mode reject

	case (opc)
		5'h00, 5'h08: begin // load and store share the layout
			u.nmid = opc[3] ? ucMovRm : ucMovMr;
			u.uixt.ucls = (f3 == 3'd7) ? iucWx : iucSc;
			u.uixt.ix = {f3[1:0], 1'b0, f3[2], 2'b00};
			u.regN = opc[3] ? rs2 : rd;
			u.regM = rs1;
			u.regO = grImm;
			u.imm  = opc[3] ? immS : immZ;
		end
		5'h18: begin
			u.nmid = ucJcmp;
			u.uixt.ix = cmpTbl[f3];
			u.regM = rs1;
			u.regO = rs2;
			u.imm  = immB;
		end
		5'h1b, 5'h05: begin // JAL, AUIPC
			if (opc == 5'h1b) begin
				u.nmid = (w[11:7] == 5'd0) ? ucJmp : ucJsr;
				u.uixt.ix = {btySw[1:0], 1'b1, btySw};
				u.imm = immJ;
			end else begin
				u.nmid = ucLeaMr;
				u.uixt.ix = {btySb[1:0], 1'b1, btySb};
				u.imm = immU;
			end
			u.regN = rd;
			u.regM = grPc;
			u.regO = grImm;
		end
		5'h19: begin
			u.nmid = (w[11:7] == 5'd0) ? ucJmp : ucJsr;
			u.regN = rd;
			u.regM = rs1;
			u.regO = grImm;
			u.imm  = immI;
		end
		5'h0d: begin
			u.nmid = ucMovIr;
			u.uixt.ix = ucixLdiLdix;
			u.regN = rd;
			u.regM = rd;
			u.regO = grImm;
			u.imm  = immU;
		end
		5'h04, 5'h0c, 5'h06, 5'h0e: begin
			word32  = opc[1];
			regForm = opc[3];
			u.nmid  = ucAlu3;
			case (f3)
				3'd0: begin
					if (regForm && w[30])
						u.uixt.ix = word32 ? ucixAluSubSl : ucixAluSub;
					else
						u.uixt.ix = word32 ? ucixAluAddSl : ucixAluAdd;
				end
				3'd1: u.uixt.ix = word32 ? ucixShadShld3 : ucixShadShldq3;
				3'd2: u.uixt.ix = word32 ? ucixAluSltSl : ucixAluSltSq;
				3'd3: u.uixt.ix = word32 ? ucixAluSltUl : ucixAluSltUq;
				3'd4: u.uixt.ix = ucixAluXor;
				3'd5: begin
					if (word32)
						u.uixt.ix = w[30] ? ucixShadShar3 : ucixShadShlr3;
					else
						u.uixt.ix = w[30] ? ucixShadSharq3 : ucixShadShlrq3;
				end
				3'd6: u.uixt.ix = ucixAluOr;
				default: u.uixt.ix = ucixAluAnd;
			endcase
			if (f3 == 3'd1 || f3 == 3'd5)
				u.nmid = word32 ? ucShad3 : ucShadq3;
			u.regN = rd;
			u.regM = rs1;
			u.regO = regForm ? rs2 : grImm;
			u.imm  = regForm ? immZ : immI;
		end
		default: ;
	endcase
	return u;
endfunction

// ==== tbRvDecode.sv ====
// ********************
// RISC-V decoder testbench
// directed and random words against the reference,
// checked in order with fixed latency
// ********************

`timescale 1ns/1ps

module tbRvDecode import decPkg::*; ();

	localparam int resetCycles = 8;
	localparam int streamWords = 300;
	localparam int maxGap      = 2;
	localparam int fixedWords  = 140; // directed, remap and reject words
	localparam int drainLimit  = 8;   // cycles a test may wait for its last results
	localparam int budgetCycles = resetCycles + 3 + fixedWords
		+ streamWords * (maxGap + 1) + 5 * (drainLimit + 3) + 20;

	logic        clock;
	logic        rstN;
	logic        istrValid;
	logic [31:0] istrWord;
	logic [2:0]  srMod;
	logic        idValid;
	uopT         idUop;

	uopT    expQ [$];
	string  nameQ [$];
	int     cycQ [$];
	int     cycleCnt = 0;
	int     errCount = 0;
	int     checkCount = 0;
	int     testErrStart;
	int     testWords;
	integer seed;

	`include "tbRvDecodeRef.svh"

	rvDecodeTop dut (
		.clock     (clock),
		.rstN      (rstN),
		.istrValid (istrValid),
		.istrWord  (istrWord),
		.srMod     (srMod),
		.idValid   (idValid),
		.idUop     (idUop)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	always @(posedge clock) cycleCnt <= cycleCnt + 1;

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	task automatic checkUop(input string name, input uopT exp, input uopT act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic checkLatency(input string name, input int exp, input int act);
		checkCount++;
		if (act != exp) begin
			errCount++;
			$display("ERR %s latency expected cycle %0d actual cycle %0d", name, exp, act);
		end
	endtask

	// drive one word with valid and queue its expectation
	task automatic sendWord(input string name, input logic [31:0] word,
		input logic [2:0] mode);
		@(posedge clock);
		#2;
		istrValid = 1'b1;
		istrWord  = word;
		srMod     = mode;
		expQ.push_back(refDecode(word, mode));
		nameQ.push_back(name);
		cycQ.push_back(cycleCnt + 2);
		testWords++;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#2;
			istrValid = 1'b0;
		end
	endtask

	task automatic drainPipe();
		idleCycles(1);
		for (int n = 0; n < drainLimit && expQ.size() != 0; n++)
			@(negedge clock);
		idleCycles(2);
	endtask

	task automatic startTest();
		testErrStart = errCount;
		testWords = 0;
	endtask

	task automatic finishTest(input string name);
		drainPipe();
		$display("test %s: %0d words, %0d errors", name, testWords, errCount - testErrStart);
	endtask

	// scoreboard samples mid-cycle
	always @(negedge clock) begin : compareOut
		uopT   expU;
		string nm;
		int    expCyc;
		if (rstN && idValid) begin
			if (expQ.size() == 0) begin
				errCount++;
				$display("idValid high at cycle %0d with no word outstanding", cycleCnt);
			end else begin
				expU   = expQ.pop_front();
				nm     = nameQ.pop_front();
				expCyc = cycQ.pop_front();
				checkUop(nm, expU, idUop);
				checkLatency(nm, expCyc, cycleCnt);
			end
		end
	end

	initial begin : watchdog
		#(budgetCycles * 20);
		$display("watchdog expired after %0d cycles, %0d results still outstanding",
			budgetCycles, expQ.size());
		$display("TEST FAILED");
		$finish;
	end

	initial begin : mainSeq
		logic [31:0] w;
		logic [4:0]  aluOpc [0:3];
		logic [4:0]  keptOpc [0:10];
		int          r;

		rstN      = 1'b0;
		istrValid = 1'b0;
		istrWord  = '0;
		srMod     = '0;
		seed      = 91;
		aluOpc  = '{5'h04, 5'h0c, 5'h06, 5'h0e};
		keptOpc = '{5'h00, 5'h08, 5'h18, 5'h1b, 5'h19, 5'h04, 5'h0c, 5'h06, 5'h0e,
			5'h05, 5'h0d};

		// reset holds the pipe empty even with words offered
		startTest();
		repeat (resetCycles) begin
			@(posedge clock);
			#2;
			istrValid = 1'b1;
			istrWord  = encI(12'h123, 5'd1, 3'd0, 5'd2, 7'h13);
			@(negedge clock);
			checkBit("reset idValid", 1'b0, idValid);
			checkUop("reset idUop", invUop(), idUop);
		end
		@(posedge clock);
		#2;
		rstN      = 1'b1;
		istrValid = 1'b0;
		repeat (2) begin
			@(negedge clock);
			checkBit("post reset idValid", 1'b0, idValid);
			checkUop("post reset idUop", invUop(), idUop);
		end
		finishTest("reset");

		startTest();
		sendWord("lw", encI(12'h7f0, 5'd10, 3'd2, 5'd11, 7'h03), 3'b000);
		sendWord("ld", encI(12'h008, 5'd9, 3'd3, 5'd12, 7'h03), 3'b000);
		sendWord("load wide", encI(12'h800, 5'd30, 3'd7, 5'd31, 7'h03), 3'b000);
		sendWord("sd", encR(7'h40, 5'd12, 5'd13, 3'd3, 5'd5, 7'h23), 3'b000);
		for (int f = 0; f < 8; f++)
			sendWord($sformatf("branch f3=%0d", f),
				encR(7'h7f, 5'd14, 5'd15, f[2:0], 5'h1f, 7'h63), 3'b000);
		sendWord("jal rd0", encU(20'h80abc, 5'd0, 7'h6f), 3'b000);
		sendWord("jal rd9", encU(20'h7f123, 5'd9, 7'h6f), 3'b000);
		sendWord("jalr rd0", encI(12'h804, 5'd1, 3'd0, 5'd0, 7'h67), 3'b000);
		sendWord("jalr rd9", encI(12'h010, 5'd1, 3'd0, 5'd9, 7'h67), 3'b000);
		sendWord("auipc", encU(20'hfffff, 5'd17, 7'h17), 3'b000);
		sendWord("lui", encU(20'h12345, 5'd18, 7'h37), 3'b000);
		// bit 30 set and clear over every ALU class
		for (int k = 0; k < 4; k++)
			for (int a = 0; a < 2; a++)
				for (int f = 0; f < 8; f++) begin
					w = encR(a ? 7'h20 : 7'h00, 5'd25, 5'd3, f[2:0], 5'd20, {aluOpc[k], 2'b11});
					sendWord($sformatf("alu opc=%h alt=%0d f3=%0d", aluOpc[k], a, f), w, 3'b000);
				end
		// every kept class with broken low bits
		for (int k = 0; k < 11; k++) begin
			w = encI(12'h123, 5'd1, 3'd0, 5'd2, {keptOpc[k], 2'b11});
			r = k % 3;
			w[1:0] = r[1:0];
			sendWord($sformatf("low bits %0d opc=%h", r, keptOpc[k]), w, 3'b000);
		end
		sendWord("misc-mem", encI(12'h000, 5'd0, 3'd0, 5'd0, 7'h0f), 3'b000);
		sendWord("system", encI(12'h001, 5'd0, 3'd0, 5'd0, 7'h73), 3'b000);
		sendWord("amo", encR(7'h00, 5'd2, 5'd3, 3'd2, 5'd6, 7'h2f), 3'b000);
		finishTest("directed");

		startTest();
		for (int i = 0; i < 32; i++)
			sendWord($sformatf("remap field %0d", i),
				encR(7'h00, i[4:0], i[4:0], 3'd0, i[4:0], 7'h33), 3'b000);
		finishTest("remap");

		startTest();
		sendWord("rd4 user", encI(12'h055, 5'd8, 3'd0, 5'd4, 7'h13), 3'b001);
		sendWord("rd4 super", encI(12'h055, 5'd8, 3'd0, 5'd4, 7'h13), 3'b000);
		sendWord("rd4 mode 110", encI(12'h055, 5'd8, 3'd0, 5'd4, 7'h13), 3'b110);
		sendWord("rd5 user", encI(12'h055, 5'd8, 3'd0, 5'd5, 7'h13), 3'b001);
		finishTest("reject");

		// back to back for the first half, then with gaps
		startTest();
		for (int i = 0; i < streamWords; i++) begin
			r = $random(seed);
			w = $random(seed);
			if (r[1:0] != 2'b00) begin
				w[6:2] = keptOpc[r[5:2] % 11];
				w[1:0] = 2'b11;
			end
			sendWord($sformatf("stream %0d", i), w, r[8:6]);
			if (i >= streamWords / 2)
				idleCycles(r[10:9] % (maxGap + 1));
		end
		finishTest("stream");

		if (expQ.size() != 0) begin
			errCount++;
			$display("%0d expected results never came out", expQ.size());
		end
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== rvDecodeTop.sv ====
// ********************
// RISC-V decoder top
// stage A classify, remap and immediates,
// then register, route and register again
// ********************

`timescale 1ns/1ps

module rvDecodeTop import decPkg::*; (
	input  logic        clock,
	input  logic        rstN,
	input  logic        istrValid,
	input  logic [31:0] istrWord,
	input  logic [2:0]  srMod,
	output logic        idValid,
	output uopT         idUop
);

	classT     cls;
	regFieldsT regs;
	immSetT    imms;
	logic      rejReq;
	stageAT    stageA;
	stageAT    stageQ;   // registered stage A
	logic      stageValid;
	uopT       uopComb;

	rvOpClassify opClassify (
		.istrWord (istrWord),
		.cls      (cls)
	);

	rvRegFieldMap regFieldMap (
		.istrWord (istrWord),
		.regs     (regs),
		.rejReq   (rejReq)
	);

	rvImmGen immGen (
		.istrWord (istrWord),
		.imms     (imms)
	);

	assign stageA = '{cls: cls, regs: regs, imms: imms, rejReq: rejReq,
		srUser: srMod[0]}; // bit 0 is user mode

	pipeStage #(.payloadT(stageAT)) stageRegA (
		.clock    (clock),
		.rstN     (rstN),
		.inValid  (istrValid),
		.inData   (stageA),
		.outValid (stageValid),
		.outData  (stageQ)
	);

	rvOperandRoute operandRoute (
		.stage (stageQ),
		.uop   (uopComb)
	);

	pipeStage #(.payloadT(uopT)) stageRegB (
		.clock    (clock),
		.rstN     (rstN),
		.inValid  (stageValid),
		.inData   (uopComb),
		.outValid (idValid),
		.outData  (idUop)
	);

endmodule

// ==== rvOperandRoute.sv ====
// ********************
// operand router
// picks registers, immediate and extended index per form
// and drops user-mode writes to the rejected field
// ********************

`timescale 1ns/1ps

module rvOperandRoute import decPkg::*; (
	input  stageAT stage,
	output uopT    uop
);

	classT     cls;
	regFieldsT rf;
	immSetT    im;
	iucT       memCls;

	assign cls = stage.cls;
	assign rf  = stage.regs;
	assign im  = stage.imms;
	assign memCls = (cls.bty == btyUq) ? iucWx : iucSc; // 64-bit moves go wide

	always_comb begin
		uop = uopInv;
		case (cls.fmid)
			fmLdRegDispReg, fmRegStRegDisp: begin
				uop.nmid = cls.nmid;
				uop.uixt = '{ucls: memCls, ix: {cls.bty[1:0], 1'b0, cls.bty[2], 2'b00}};
				uop.regM = rf.regM;
				uop.regO = grImm;
				if (cls.fmid == fmLdRegDispReg) begin
					uop.regN = rf.regN; // load target
					uop.imm  = im.immIu;
				end else begin
					uop.regN = rf.regO; // store data
					uop.imm  = im.immS;
				end
			end
			fmRegPc: begin
				uop.nmid = cls.nmid;
				uop.uixt = '{ucls: iucSc, ix: cls.ucmdIx};
				uop.regN = grZzr;
				uop.regM = rf.regM;
				uop.regO = rf.regO;
				uop.imm  = im.immB;
			end
			fmPcDisp8: begin
				uop.nmid = cls.nmid;
				uop.uixt = '{ucls: iucSc, ix: {cls.bty[1:0], 1'b1, cls.bty}};
				uop.regN = rf.regN;
				uop.regM = grPc;
				uop.regO = grImm;
				case (cls.ity)
					itySw:   uop.imm = im.immJ; // JAL
					itySb:   uop.imm = im.immU; // AUIPC
					default: uop = uopInv;
				endcase
			end
			fmRegImmReg: begin
				uop.nmid = cls.nmid;
				uop.uixt = '{ucls: iucSc, ix: cls.ucmdIx};
				uop.regN = rf.regN;
				uop.regM = rf.regM;
				uop.regO = grImm;
				uop.imm  = im.immIs;
			end
			fmRegReg: begin
				uop.nmid = cls.nmid;
				uop.uixt = '{ucls: iucSc, ix: cls.ucmdIx};
				uop.regN = rf.regN;
				uop.regM = rf.regM;
				uop.regO = rf.regO;
				uop.imm  = im.immIu;
			end
			fmImm8Reg: begin
				uop.nmid = cls.nmid;
				uop.uixt = '{ucls: iucSc, ix: cls.ucmdIx};
				uop.regN = rf.regN;
				uop.regM = rf.regN; // LUI reads its own target
				uop.regO = grImm;
				uop.imm  = im.immU;
			end
			fmInv, fmZ: uop = uopInv;
			default:    uop = uopInv;
		endcase

		if (stage.rejReq && stage.srUser)
			uop = uopInv; // user mode reject
	end

	// a known class must come with known register ids for the core
	always_comb begin
		if (!$isunknown(cls) && cls.fmid != fmInv)
			regsKnown: assert final (!$isunknown({uop.regN, uop.regM, uop.regO}));
	end

endmodule

// ==== rvImmGen.sv ====
// ********************
// immediate generator
// every immediate variant the router may pick
// ********************

`timescale 1ns/1ps

module rvImmGen import decPkg::*; (
	input  logic [31:0] istrWord,
	output immSetT      imms
);

	logic sgn;

	assign sgn = istrWord[31];

	// I-type, signed and unsigned
	assign imms.immIs = {{21{sgn}}, istrWord[31:20]};
	assign imms.immIu = {21'd0, istrWord[31:20]};

	// S-type store displacement
	assign imms.immS = {{21{sgn}}, istrWord[31:25], istrWord[11:7]};

	// branch offset in halfwords
	assign imms.immB = {
		{21{sgn}},
		istrWord[31],
		istrWord[7],
		istrWord[30:25],
		istrWord[11:8]
	};

	// jump offset in halfwords
	assign imms.immJ = {
		{13{sgn}},
		istrWord[31],
		istrWord[19:12],
		istrWord[20],
		istrWord[30:21]
	};

	assign imms.immU = {1'b0, istrWord[31:12], 12'h000}; // ext bit clear

endmodule

// ==== rvRegFieldMap.sv ====
// ********************
// register field map
// rd, rs1 and rs2 onto core register ids,
// low fields land on the special registers
// ********************

`timescale 1ns/1ps

module rvRegFieldMap import decPkg::*; (
	input  logic [31:0] istrWord,
	output regFieldsT   regs,
	output logic        rejReq
);

	function automatic gprT mapField(input logic [4:0] field);
		gprT id;
		if (field[4:3] == 2'b00) begin
			case (field[2:0])
				3'd0:    id = grZzr;
				3'd1:    id = grLr;
				3'd2:    id = grSp;
				3'd3:    id = grGbr;
				3'd4:    id = grTbr;
				3'd5:    id = grDhr;
				3'd6:    id = grDlr;
				default: id = grR7;
			endcase
		end else begin
			id = {2'b00, field}; // plain gpr
		end
		return id;
	endfunction

	assign regs.regN = mapField(istrWord[11:7]);
	assign regs.regM = mapField(istrWord[19:15]);
	assign regs.regO = mapField(istrWord[24:20]);

	// writing TBR is kept from user mode
	assign rejReq = (istrWord[11:7] == 5'd4);

endmodule

// ==== rvOpClassify.sv ====
// ********************
// opcode classifier
// major opcode and funct fields to micro-op,
// form, immediate type and width class
// ********************

`timescale 1ns/1ps

module rvOpClassify import decPkg::*; (
	input  logic [31:0] istrWord,
	output classT       cls
);

	logic [2:0] funct3;
	logic       rdIsZero;
	logic       altBit;   // bit 30 selects sub or arithmetic shift
	logic       isRegForm; // OP / OP-32
	logic       isWord;    // the 32-bit ALU classes

	assign funct3    = istrWord[14:12];
	assign rdIsZero  = (istrWord[11:7] == 5'd0);
	assign altBit    = istrWord[30];
	assign isRegForm = istrWord[5];
	assign isWord    = istrWord[3];

	always_comb begin
		cls = '{nmid: ucInvop, fmid: fmInv, ity: itySb, bty: btySb, ucmdIx: 6'd0};
		if (istrWord[1:0] == 2'b11) begin
			case (istrWord[6:2])
				5'b00000: cls = '{nmid: ucMovMr, fmid: fmLdRegDispReg, ity: itySb,
					bty: funct3, ucmdIx: 6'd0}; // LOAD
				5'b01000: cls = '{nmid: ucMovRm, fmid: fmRegStRegDisp, ity: itySb,
					bty: funct3, ucmdIx: 6'd0}; // STORE
				5'b11000: begin // BRANCH
					cls.nmid = ucJcmp;
					cls.fmid = fmRegPc;
					cls.ity  = ityUb;
					case (funct3)
						3'b001:  cls.ucmdIx = ucixJcmpQne;
						3'b100:  cls.ucmdIx = ucixJcmpQlt;
						3'b101:  cls.ucmdIx = ucixJcmpQge;
						3'b110:  cls.ucmdIx = ucixJcmpQbl;
						3'b111:  cls.ucmdIx = ucixJcmpQhs;
						default: cls.ucmdIx = ucixJcmpQeq; // 0, 2 and 3
					endcase
				end
				5'b11001: cls = '{nmid: rdIsZero ? ucJmp : ucJsr, fmid: fmRegImmReg,
					ity: itySw, bty: btySb, ucmdIx: 6'd0}; // JALR
				5'b11011: cls = '{nmid: rdIsZero ? ucJmp : ucJsr, fmid: fmPcDisp8,
					ity: itySw, bty: btySw, ucmdIx: 6'd0}; // JAL
				5'b00101: cls = '{nmid: ucLeaMr, fmid: fmPcDisp8, ity: itySb,
					bty: btySb, ucmdIx: 6'd0}; // AUIPC
				5'b01101: cls = '{nmid: ucMovIr, fmid: fmImm8Reg, ity: ityUb,
					bty: btySb, ucmdIx: ucixLdiLdix}; // LUI
				5'b00100, 5'b01100, 5'b00110, 5'b01110: begin
					// OP-IMM, OP, OP-IMM-32, OP-32
					cls.nmid = ucAlu3;
					cls.fmid = isRegForm ? fmRegReg : fmRegImmReg;
					cls.ity  = isRegForm ? itySb : itySw;
					case (funct3)
						3'b000: begin
							if (isRegForm && altBit)
								cls.ucmdIx = isWord ? ucixAluSubSl : ucixAluSub;
							else
								cls.ucmdIx = isWord ? ucixAluAddSl : ucixAluAdd;
						end
						3'b001: begin
							cls.nmid   = isWord ? ucShad3 : ucShadq3;
							cls.ucmdIx = isWord ? ucixShadShld3 : ucixShadShldq3;
						end
						3'b010: cls.ucmdIx = isWord ? ucixAluSltSl : ucixAluSltSq;
						3'b011: cls.ucmdIx = isWord ? ucixAluSltUl : ucixAluSltUq;
						3'b100: cls.ucmdIx = ucixAluXor;
						3'b101: begin
							cls.nmid = isWord ? ucShad3 : ucShadq3;
							if (isWord)
								cls.ucmdIx = altBit ? ucixShadShar3 : ucixShadShlr3;
							else
								cls.ucmdIx = altBit ? ucixShadSharq3 : ucixShadShlrq3;
						end
						3'b110: cls.ucmdIx = ucixAluOr;
						default: cls.ucmdIx = ucixAluAnd;
					endcase
				end
				default: ; // stays invalid
			endcase
		end
	end

	// the router only knows the forms below and expects a micro-op with each
	always_comb begin
		if (!$isunknown(istrWord) && istrWord[1:0] == 2'b11)
			formKnown: assert final (cls.fmid inside {fmInv, fmRegReg, fmRegImmReg,
				fmLdRegDispReg, fmRegStRegDisp, fmImm8Reg, fmRegPc, fmPcDisp8}
				&& ((cls.fmid == fmInv) == (cls.nmid == ucInvop)));
	end

endmodule

// ==== pipeStage.sv ====
// ********************
// pipeline register
// carries a valid bit and any payload type one cycle
// ********************

`timescale 1ns/1ps

module pipeStage #(
	parameter type payloadT = logic [7:0]
) (
	input  logic    clock,
	input  logic    rstN,
	input  logic    inValid,
	input  payloadT inData,
	output logic    outValid,
	output payloadT outData
);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			outData  <= '0; // zero payload doubles as the invalid uop
		end else begin
			outValid <= inValid;
			outData  <= inData;
		end
	end

	// downstream logic trusts the strobe without qualifying it
	validKnown: assert property (@(posedge clock) disable iff (!rstN)
		!$isunknown(outValid));

endmodule

// ==== decPkg.sv ====
// ********************
// decode package
// register ids, micro-op, form and width codes
// and the pipeline payload structs of the RISC-V decoder
// ********************

package decPkg;

	typedef logic [6:0] gprT;
	typedef logic [32:0] immT; // bit 32 is the extension bit
	typedef logic [5:0] nmidT;
	typedef logic [3:0] fmidT;
	typedef logic [3:0] ityT;
	typedef logic [2:0] btyT;
	typedef logic [2:0] iucT;

	// special registers of the core
	// fields 8..31 keep their own number
	localparam gprT grZzr = 7'h00;
	localparam gprT grLr  = 7'h41;
	localparam gprT grSp  = 7'h42;
	localparam gprT grGbr = 7'h43;
	localparam gprT grTbr = 7'h44;
	localparam gprT grDhr = 7'h45;
	localparam gprT grDlr = 7'h46;
	localparam gprT grR7  = 7'h07;
	localparam gprT grPc  = 7'h40;
	localparam gprT grImm = 7'h5E; // operand taken from imm

	// micro-op codes
	localparam nmidT ucInvop  = 6'h00;
	localparam nmidT ucMovRm  = 6'h01;
	localparam nmidT ucMovMr  = 6'h02;
	localparam nmidT ucJcmp   = 6'h08;
	localparam nmidT ucJsr    = 6'h09;
	localparam nmidT ucJmp    = 6'h0A;
	localparam nmidT ucAlu3   = 6'h10;
	localparam nmidT ucShad3  = 6'h14;
	localparam nmidT ucShadq3 = 6'h15;
	localparam nmidT ucLeaMr  = 6'h18;
	localparam nmidT ucMovIr  = 6'h1C;

	localparam iucT iucSc = 3'd0; // normal
	localparam iucT iucWx = 3'd1; // wide

	// sub-index codes
	localparam logic [5:0] ucixAluAdd    = 6'h00;
	localparam logic [5:0] ucixAluSub    = 6'h01;
	localparam logic [5:0] ucixAluAddSl  = 6'h02;
	localparam logic [5:0] ucixAluSubSl  = 6'h03;
	localparam logic [5:0] ucixAluSltSq  = 6'h04;
	localparam logic [5:0] ucixAluSltUq  = 6'h05;
	localparam logic [5:0] ucixAluSltSl  = 6'h06;
	localparam logic [5:0] ucixAluSltUl  = 6'h07;
	localparam logic [5:0] ucixAluXor    = 6'h08;
	localparam logic [5:0] ucixAluOr     = 6'h09;
	localparam logic [5:0] ucixAluAnd    = 6'h0A;
	localparam logic [5:0] ucixShadShld3  = 6'h00;
	localparam logic [5:0] ucixShadShlr3  = 6'h01;
	localparam logic [5:0] ucixShadShar3  = 6'h02;
	localparam logic [5:0] ucixShadShldq3 = 6'h04;
	localparam logic [5:0] ucixShadShlrq3 = 6'h05;
	localparam logic [5:0] ucixShadSharq3 = 6'h06;
	localparam logic [5:0] ucixJcmpQeq = 6'h10;
	localparam logic [5:0] ucixJcmpQne = 6'h11;
	localparam logic [5:0] ucixJcmpQlt = 6'h12;
	localparam logic [5:0] ucixJcmpQge = 6'h13;
	localparam logic [5:0] ucixJcmpQbl = 6'h14;
	localparam logic [5:0] ucixJcmpQhs = 6'h15;
	localparam logic [5:0] ucixLdiLdix = 6'h20;

	// form codes
	localparam fmidT fmZ            = 4'h0;
	localparam fmidT fmInv          = 4'h1;
	localparam fmidT fmRegReg       = 4'h2;
	localparam fmidT fmRegImmReg    = 4'h3;
	localparam fmidT fmLdRegDispReg = 4'h4;
	localparam fmidT fmRegStRegDisp = 4'h5;
	localparam fmidT fmImm8Reg      = 4'h6;
	localparam fmidT fmRegPc        = 4'h7;
	localparam fmidT fmPcDisp8      = 4'h8;

	localparam ityT itySb = 4'h0;
	localparam ityT itySw = 4'h1;
	localparam ityT ityUb = 4'h4;

	localparam btyT btySb = 3'd0;
	localparam btyT btySw = 3'd1;
	localparam btyT btyUq = 3'd7; // unsigned 64

	typedef struct packed {
		iucT        ucls;
		logic [5:0] ix;
	} uixtT;

	typedef struct packed {
		gprT regN; // rd
		gprT regM; // rs1
		gprT regO; // rs2
	} regFieldsT;

	typedef struct packed {
		immT immIs;
		immT immIu;
		immT immS;
		immT immB;
		immT immJ;
		immT immU;
	} immSetT;

	typedef struct packed {
		nmidT       nmid;
		fmidT       fmid;
		ityT        ity;
		btyT        bty;
		logic [5:0] ucmdIx;
	} classT;

	typedef struct packed {
		classT     cls;
		regFieldsT regs;
		immSetT    imms;
		logic      rejReq;
		logic      srUser;
	} stageAT;

	typedef struct packed {
		nmidT nmid;
		uixtT uixt;
		gprT  regN;
		gprT  regM;
		gprT  regO;
		immT  imm;
	} uopT;

	// all zero, which is also what a cleared pipeStage holds
	localparam uopT uopInv = '{nmid: ucInvop, uixt: '{ucls: iucSc, ix: 6'd0},
		regN: grZzr, regM: grZzr, regO: grZzr, imm: '0};

endpackage
